//--- hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Cache geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = DATA_W * LINE_WORDS;
    localparam int SETS       = 16;

    // Address split: tag | index | byte offset
    localparam int OFFSET_W = $clog2(LINE_W / 8);
    localparam int INDEX_W  = $clog2(SETS);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // Controller states
    typedef enum logic [2:0] {
        DCACHE_IDLE       = 3'd0,
        DCACHE_READ       = 3'd1,
        DCACHE_WRITE      = 3'd2,
        DCACHE_ALLOCATE   = 3'd3,
        DCACHE_WRITE_BACK = 3'd4,
        DCACHE_FLUSH      = 3'd5
    } type_dcache_states_e;

    // One cache line
    // Arrays and the memory port move it as a flat word, the LSU side picks words out of it
    typedef union packed {
        logic [LINE_W-1:0]                 flat;
        logic [LINE_WORDS-1:0][DATA_W-1:0] words;
    } dcache_line_u;

endpackage

`default_nettype wire

//--- hw/wb_dcache_controller.sv
`timescale 1ns/1ns
`default_nettype none

module wb_dcache_controller import dcache_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,

    // Status from the datapath
    input  logic cache_hit_i,
    input  logic cache_dirty_bit_i,
    input  logic dcache_flush_i,
    input  logic dcache_flush_done_i,

    // Strobes to the datapath
    output logic cache_wr_o,
    output logic cache_line_wr_o,
    output logic cache_writeback_req_o,

    // LSU side
    input  logic lsummu2dcache_req_i,
    input  logic lsummu2dcache_wr_i,
    output logic dcache2lsummu_ack_o,

    // Memory side
    input  logic mem2dcache_ack_i,
    output logic dcache2mem_req_o,
    output logic dcache2mem_wr_o,
    input  logic dmem_sel_i
);

    type_dcache_states_e dcache_state_ff;
    type_dcache_states_e dcache_state_next;

    logic lsu_valid;
    logic dcache_hit;
    logic dcache_miss;

    // Only requests to cacheable data memory are served
    assign lsu_valid   = lsummu2dcache_req_i & dmem_sel_i;
    assign dcache_hit  = lsu_valid & cache_hit_i;
    assign dcache_miss = lsu_valid & ~cache_hit_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            dcache_state_ff <= DCACHE_IDLE;
        end else begin
            dcache_state_ff <= dcache_state_next;
        end
    end

    always_comb begin
        dcache_state_next     = dcache_state_ff;
        cache_wr_o            = 1'b0;
        cache_line_wr_o       = 1'b0;
        cache_writeback_req_o = 1'b0;
        dcache2lsummu_ack_o   = 1'b0;
        dcache2mem_req_o      = 1'b0;
        dcache2mem_wr_o       = 1'b0;

        unique case (dcache_state_ff)
            DCACHE_IDLE: begin
                // Flush has priority over any pending access
                if (dcache_flush_i) begin
                    dcache_state_next = DCACHE_FLUSH;
                end else if (dcache_hit) begin
                    if (lsummu2dcache_wr_i) begin
                        // Store lands in the line on this edge
                        cache_wr_o        = 1'b1;
                        dcache_state_next = DCACHE_WRITE;
                    end else begin
                        dcache_state_next = DCACHE_READ;
                    end
                end else if (dcache_miss) begin
                    if (cache_dirty_bit_i) begin
                        // Victim goes out first, request starts right away
                        dcache2mem_req_o      = 1'b1;
                        dcache2mem_wr_o       = 1'b1;
                        cache_writeback_req_o = 1'b1;
                        dcache_state_next     = DCACHE_WRITE_BACK;
                    end else begin
                        dcache_state_next = DCACHE_ALLOCATE;
                    end
                end
            end
            DCACHE_READ: begin
                // Read word is on the datapath output in this cycle
                dcache2lsummu_ack_o = 1'b1;
                dcache_state_next   = DCACHE_IDLE;
            end
            DCACHE_WRITE: begin
                dcache2lsummu_ack_o = 1'b1;
                dcache_state_next   = DCACHE_IDLE;
            end
            DCACHE_ALLOCATE: begin
                dcache2mem_req_o = 1'b1;
                if (mem2dcache_ack_i) begin
                    // Fill on the ack edge, the access then completes as a hit
                    cache_line_wr_o   = 1'b1;
                    dcache_state_next = DCACHE_IDLE;
                end
            end
            DCACHE_WRITE_BACK: begin
                dcache2mem_req_o      = 1'b1;
                dcache2mem_wr_o       = 1'b1;
                cache_writeback_req_o = 1'b1;
                if (mem2dcache_ack_i) begin
                    dcache_state_next = DCACHE_ALLOCATE;
                end
            end
            DCACHE_FLUSH: begin
                // Bounce back to idle until the walker reports completion
                dcache_state_next = DCACHE_IDLE;
                if (dcache_flush_done_i) begin
                    dcache2lsummu_ack_o = 1'b1;
                end
            end
            default: begin
                dcache_state_next = DCACHE_IDLE;
            end
        endcase

        // Address outside data memory kills whatever is in flight
        if (!dmem_sel_i) begin
            dcache_state_next     = DCACHE_IDLE;
            cache_wr_o            = 1'b0;
            cache_writeback_req_o = 1'b0;
            dcache2lsummu_ack_o   = 1'b0;
            dcache2mem_req_o      = 1'b0;
            dcache2mem_wr_o       = 1'b0;
        end
    end

    // A filled line must hit for the request that is still held
    a_fill_then_hit: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        cache_line_wr_o |=> (!lsummu2dcache_req_i || !dmem_sel_i || cache_hit_i)
    ) else $error("line fill did not produce a hit");

    // A store leaves its line dirty
    a_store_sets_dirty: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        cache_wr_o |=> (!lsummu2dcache_req_i || !dmem_sel_i || cache_dirty_bit_i)
    ) else $error("store did not mark the line dirty");

endmodule

`default_nettype wire

//--- hw/wb_dcache_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module wb_dcache_datapath import dcache_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // LSU request fields
    input  logic [ADDR_W-1:0]     lsummu2dcache_addr_i,
    input  logic [DATA_W/8-1:0]   lsummu2dcache_sel_i,
    input  logic [DATA_W-1:0]     lsummu2dcache_wdata_i,

    // Strobes from the controller
    input  logic                  cache_wr_i,
    input  logic                  cache_line_wr_i,
    input  logic                  cache_writeback_req_i,
    input  logic                  ctrl_mem_req_i,
    input  logic                  ctrl_mem_wr_i,
    input  logic                  dcache_flush_i,

    // Memory response
    input  logic                  mem2dcache_ack_i,
    input  logic [LINE_W-1:0]     mem2dcache_data_i,

    // Status to the controller
    output logic                  cache_hit_o,
    output logic                  cache_dirty_bit_o,
    output logic                  dcache_flush_done_o,

    // Read data to the LSU
    output logic [DATA_W-1:0]     dcache2lsummu_data_o,

    // Memory request
    output logic                  dcache2mem_req_o,
    output logic                  dcache2mem_wr_o,
    output logic [ADDR_W-1:0]     dcache2mem_addr_o,
    output logic [LINE_W-1:0]     dcache2mem_data_o
);

    // Arrays, only valid and dirty are cleared by reset
    logic [TAG_W-1:0]   tag_q [SETS];
    dcache_line_u       data_q [SETS];
    logic [SETS-1:0]    valid_q;
    logic [SETS-1:0]    dirty_q;

    // Request address fields
    logic [TAG_W-1:0]              req_tag;
    logic [INDEX_W-1:0]            req_idx;
    logic [$clog2(LINE_WORDS)-1:0] req_word;

    dcache_line_u       req_line;
    dcache_line_u       merged_line;
    logic [ADDR_W-1:0]  victim_addr;
    logic [ADDR_W-1:0]  fill_addr;

    // Flush walker
    logic               walk_q;
    logic               walk_done_q;
    logic [INDEX_W-1:0] walk_idx_q;
    logic               walk_busy;
    logic               walk_victim;
    logic               walk_step;

    assign req_tag  = lsummu2dcache_addr_i[ADDR_W-1 -: TAG_W];
    assign req_idx  = lsummu2dcache_addr_i[OFFSET_W +: INDEX_W];
    assign req_word = lsummu2dcache_addr_i[OFFSET_W-1:$clog2(DATA_W/8)];

    assign req_line = data_q[req_idx];

    assign cache_hit_o       = valid_q[req_idx] & (tag_q[req_idx] == req_tag);
    assign cache_dirty_bit_o = valid_q[req_idx] & dirty_q[req_idx];

    assign dcache2lsummu_data_o = req_line.words[req_word];

    // Byte lanes of the store replace the matching bytes of the hit word
    always_comb begin
        merged_line = req_line;
        for (int b = 0; b < DATA_W / 8; b++) begin
            if (lsummu2dcache_sel_i[b]) begin
                merged_line.words[req_word][8*b +: 8] = lsummu2dcache_wdata_i[8*b +: 8];
            end
        end
    end

    // Line aligned addresses for the resident line and the requested line
    assign victim_addr = {tag_q[req_idx], req_idx, {OFFSET_W{1'b0}}};
    assign fill_addr   = {req_tag, req_idx, {OFFSET_W{1'b0}}};

    always_ff @(posedge clk_i) begin
        if (cache_line_wr_i) begin
            tag_q[req_idx]       <= req_tag;
            data_q[req_idx].flat <= mem2dcache_data_i;
        end else if (cache_wr_i) begin
            data_q[req_idx] <= merged_line;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (walk_step) begin
            // Walker leaves every set it passes invalid and clean
            valid_q[walk_idx_q] <= 1'b0;
            dirty_q[walk_idx_q] <= 1'b0;
        end else if (cache_line_wr_i) begin
            valid_q[req_idx] <= 1'b1;
            dirty_q[req_idx] <= 1'b0;
        end else if (cache_wr_i) begin
            dirty_q[req_idx] <= 1'b1;
        end
    end

    assign walk_busy   = walk_q | walk_done_q;
    assign walk_victim = walk_q & valid_q[walk_idx_q] & dirty_q[walk_idx_q];

    // Clean sets pass in one cycle, dirty ones wait for the memory ack
    assign walk_step = walk_q & (~walk_victim | mem2dcache_ack_i);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            walk_q      <= 1'b0;
            walk_done_q <= 1'b0;
            walk_idx_q  <= '0;
        end else if (walk_q) begin
            if (walk_step) begin
                walk_idx_q <= walk_idx_q + 1'b1;
                if (walk_idx_q == INDEX_W'(SETS - 1)) begin
                    walk_q      <= 1'b0;
                    walk_done_q <= 1'b1;
                end
            end
        end else if (walk_done_q) begin
            if (!dcache_flush_i) begin
                walk_done_q <= 1'b0;
            end
        end else if (dcache_flush_i) begin
            walk_q     <= 1'b1;
            walk_idx_q <= '0;
        end
    end

    // Held until the flush drops, so the controller sees it in a FLUSH cycle
    assign dcache_flush_done_o = walk_done_q;

    // Memory port belongs to the walker for the whole flush
    always_comb begin
        if (walk_busy) begin
            dcache2mem_req_o  = walk_victim;
            dcache2mem_wr_o   = walk_victim;
            dcache2mem_addr_o = {tag_q[walk_idx_q], walk_idx_q, {OFFSET_W{1'b0}}};
            dcache2mem_data_o = data_q[walk_idx_q].flat;
        end else begin
            dcache2mem_req_o  = ctrl_mem_req_i;
            dcache2mem_wr_o   = ctrl_mem_wr_i;
            dcache2mem_addr_o = cache_writeback_req_i ? victim_addr : fill_addr;
            dcache2mem_data_o = req_line.flat;
        end
    end

    // Controller must stay away from the arrays while the walker owns them
    a_no_fill_in_walk: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(walk_busy && cache_line_wr_i)
    ) else $error("line fill during flush walk");

endmodule

`default_nettype wire

//--- hw/wb_dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module wb_dcache_top import dcache_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // LSU side
    input  logic                  lsummu2dcache_req_i,
    input  logic                  lsummu2dcache_wr_i,
    input  logic [ADDR_W-1:0]     lsummu2dcache_addr_i,
    input  logic [DATA_W/8-1:0]   lsummu2dcache_sel_i,
    input  logic [DATA_W-1:0]     lsummu2dcache_wdata_i,
    output logic                  dcache2lsummu_ack_o,
    output logic [DATA_W-1:0]     dcache2lsummu_data_o,
    input  logic                  dcache_flush_i,
    input  logic                  dmem_sel_i,

    // Memory side
    output logic                  dcache2mem_req_o,
    output logic                  dcache2mem_wr_o,
    output logic [ADDR_W-1:0]     dcache2mem_addr_o,
    output logic [LINE_W-1:0]     dcache2mem_data_o,
    input  logic                  mem2dcache_ack_i,
    input  logic [LINE_W-1:0]     mem2dcache_data_i
);

    logic cache_hit;
    logic cache_dirty_bit;
    logic dcache_flush_done;
    logic cache_wr;
    logic cache_line_wr;
    logic cache_writeback_req;

    // Controller memory strobes, routed through the datapath
    logic ctrl_mem_req;
    logic ctrl_mem_wr;

    wb_dcache_controller wb_dcache_controller_i (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .cache_hit_i           (cache_hit),
        .cache_dirty_bit_i     (cache_dirty_bit),
        .dcache_flush_i        (dcache_flush_i),
        .dcache_flush_done_i   (dcache_flush_done),
        .cache_wr_o            (cache_wr),
        .cache_line_wr_o       (cache_line_wr),
        .cache_writeback_req_o (cache_writeback_req),
        .lsummu2dcache_req_i   (lsummu2dcache_req_i),
        .lsummu2dcache_wr_i    (lsummu2dcache_wr_i),
        .dcache2lsummu_ack_o   (dcache2lsummu_ack_o),
        .mem2dcache_ack_i      (mem2dcache_ack_i),
        .dcache2mem_req_o      (ctrl_mem_req),
        .dcache2mem_wr_o       (ctrl_mem_wr),
        .dmem_sel_i            (dmem_sel_i)
    );

    wb_dcache_datapath wb_dcache_datapath_i (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .lsummu2dcache_addr_i  (lsummu2dcache_addr_i),
        .lsummu2dcache_sel_i   (lsummu2dcache_sel_i),
        .lsummu2dcache_wdata_i (lsummu2dcache_wdata_i),
        .cache_wr_i            (cache_wr),
        .cache_line_wr_i       (cache_line_wr),
        .cache_writeback_req_i (cache_writeback_req),
        .ctrl_mem_req_i        (ctrl_mem_req),
        .ctrl_mem_wr_i         (ctrl_mem_wr),
        .dcache_flush_i        (dcache_flush_i),
        .mem2dcache_ack_i      (mem2dcache_ack_i),
        .mem2dcache_data_i     (mem2dcache_data_i),
        .cache_hit_o           (cache_hit),
        .cache_dirty_bit_o     (cache_dirty_bit),
        .dcache_flush_done_o   (dcache_flush_done),
        .dcache2lsummu_data_o  (dcache2lsummu_data_o),
        .dcache2mem_req_o      (dcache2mem_req_o),
        .dcache2mem_wr_o       (dcache2mem_wr_o),
        .dcache2mem_addr_o     (dcache2mem_addr_o),
        .dcache2mem_data_o     (dcache2mem_data_o)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_dcache \
    -f wb_dcache.f -Mdir obj_dir -o sim_wb_dcache &&
./obj_dir/sim_wb_dcache | tee /dev/stderr | grep -q -x -F "PASS: all tests" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- sim/tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model import dcache_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_i,
    input  logic              wr_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [LINE_W-1:0] data_i,
    output logic              ack_o,
    output logic [LINE_W-1:0] data_o
);

    // 1 KB of backing store, word addressed by addr[9:2]
    logic [DATA_W-1:0] mem_q [256];

    integer            seed = 32'h4d78ebcf;
    logic              busy_q;
    logic              wr_q;
    logic [ADDR_W-1:0] addr_q;
    logic [LINE_W-1:0] wdata_q;
    int                wait_q;

    // Fill pattern depends on the whole word address
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem_q[i] = (32'(i) * 32'h9e3779b1) ^ 32'h3c5a0f96;
        end
    end

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            ack_o  <= 1'b0;
            data_o <= '0;
        end else if (ack_o) begin
            // Request level is still up in the ack cycle, so it is not taken again
            ack_o  <= 1'b0;
            busy_q <= 1'b0;
        end else if (busy_q) begin
            if (wait_q == 0) begin
                ack_o <= 1'b1;
                for (int w = 0; w < LINE_WORDS; w++) begin
                    if (wr_q) begin
                        mem_q[{addr_q[9:4], w[1:0]}] = wdata_q[DATA_W*w +: DATA_W];
                    end else begin
                        data_o[DATA_W*w +: DATA_W] <= mem_q[{addr_q[9:4], w[1:0]}];
                    end
                end
            end else begin
                wait_q <= wait_q - 1;
            end
        end else if (req_i) begin
            busy_q  <= 1'b1;
            wr_q    <= wr_i;
            addr_q  <= addr_i;
            wdata_q <= data_i;
            wait_q  <= int'($unsigned($random(seed)) % 6);
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_wb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wb_dcache import dcache_pkg::*; ();

    logic                clk;
    logic                rst_n;
    logic                lsu_req;
    logic                lsu_wr;
    logic [ADDR_W-1:0]   lsu_addr;
    logic [DATA_W/8-1:0] lsu_sel;
    logic [DATA_W-1:0]   lsu_wdata;
    logic                lsu_ack;
    logic [DATA_W-1:0]   lsu_rdata;
    logic                flush;
    logic                dmem_sel;
    logic                mem_req;
    logic                mem_wr;
    logic [ADDR_W-1:0]   mem_addr;
    dcache_line_u        mem_wdata;
    logic                mem_ack;
    logic [LINE_W-1:0]   mem_rdata;

    // Architectural value of every word in the 1 KB test range
    logic [DATA_W-1:0]   ref_mem [256];

    integer seed;
    int     errors;
    int     n_access;
    int     n_wb;
    int     n_flush;
    bit     mem_req_seen;

    wb_dcache_top wb_dcache_top_i (
        .clk_i                 (clk),
        .rst_ni                (rst_n),
        .lsummu2dcache_req_i   (lsu_req),
        .lsummu2dcache_wr_i    (lsu_wr),
        .lsummu2dcache_addr_i  (lsu_addr),
        .lsummu2dcache_sel_i   (lsu_sel),
        .lsummu2dcache_wdata_i (lsu_wdata),
        .dcache2lsummu_ack_o   (lsu_ack),
        .dcache2lsummu_data_o  (lsu_rdata),
        .dcache_flush_i        (flush),
        .dmem_sel_i            (dmem_sel),
        .dcache2mem_req_o      (mem_req),
        .dcache2mem_wr_o       (mem_wr),
        .dcache2mem_addr_o     (mem_addr),
        .dcache2mem_data_o     (mem_wdata),
        .mem2dcache_ack_i      (mem_ack),
        .mem2dcache_data_i     (mem_rdata)
    );

    tb_mem_model mem_i (
        .clk_i  (clk),
        .rst_ni (rst_n),
        .req_i  (mem_req),
        .wr_i   (mem_wr),
        .addr_i (mem_addr),
        .data_i (mem_wdata),
        .ack_o  (mem_ack),
        .data_o (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int word_idx(input logic [ADDR_W-1:0] addr);
        return int'(addr[9:2]);
    endfunction

    // Every line written to memory must carry the architectural values
    always @(posedge clk) begin
        if (mem_req) begin
            mem_req_seen = 1'b1;
        end
        if (mem_req && mem_wr && mem_ack) begin
            n_wb++;
            for (int w = 0; w < LINE_WORDS; w++) begin
                assert (mem_wdata.words[w] === ref_mem[word_idx(mem_addr) + w]) else begin
                    errors++;
                    $display("[FAIL] %0t dcache2mem_data_o line %h word %0d: got %h expected %h",
                             $time, mem_addr, w, mem_wdata.words[w],
                             ref_mem[word_idx(mem_addr) + w]);
                end
            end
        end
    end

    task automatic run_access(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [3:0] sel, input logic [DATA_W-1:0] wdata,
                              input bit expect_hit, input bit expect_miss);
        int                cycles;
        logic [DATA_W-1:0] merged;
        cycles       = 0;
        mem_req_seen = 1'b0;
        lsu_req   <= 1'b1;
        lsu_wr    <= wr;
        lsu_addr  <= addr;
        lsu_sel   <= sel;
        lsu_wdata <= wdata;
        do begin
            @(posedge clk);
            cycles++;
        end while (!lsu_ack && cycles < 200);
        lsu_req <= 1'b0;
        n_access++;
        if (!lsu_ack) begin
            errors++;
            $display("Access to %h got no ack within 200 cycles", addr);
        end else if (wr) begin
            merged = ref_mem[word_idx(addr)];
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    merged[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            ref_mem[word_idx(addr)] = merged;
        end else begin
            assert (lsu_rdata === ref_mem[word_idx(addr)]) else begin
                errors++;
                $display("[FAIL] %0t dcache2lsummu_data_o addr %h: got %h expected %h",
                         $time, addr, lsu_rdata, ref_mem[word_idx(addr)]);
            end
        end
        if (expect_hit) begin
            assert (cycles == 2) else begin
                errors++;
                $display("[FAIL] %0t dcache2lsummu_ack_o latency addr %h: got %0d expected 2",
                         $time, addr, cycles);
            end
        end
        if (expect_miss) begin
            assert (mem_req_seen) else begin
                errors++;
                $display("Access to %h after flush made no memory request", addr);
            end
        end
        @(posedge clk);
    endtask

    task automatic check_deselect(input logic [ADDR_W-1:0] addr);
        dmem_sel <= 1'b0;
        lsu_req  <= 1'b1;
        lsu_wr   <= 1'b0;
        lsu_addr <= addr;
        repeat (10) begin
            @(posedge clk);
            assert (!lsu_ack && !mem_req) else begin
                errors++;
                $display("Request with dmem_sel_i low was served at %0t", $time);
            end
        end
        lsu_req  <= 1'b0;
        dmem_sel <= 1'b1;
        @(posedge clk);
    endtask

    task automatic run_flush();
        int cycles;
        cycles = 0;
        flush <= 1'b1;
        do begin
            @(posedge clk);
            cycles++;
        end while (!lsu_ack && cycles < 200);
        flush <= 1'b0;
        n_flush++;
        if (!lsu_ack) begin
            errors++;
            $display("Flush got no ack within 200 cycles");
        end
        @(posedge clk);
        for (int i = 0; i < 256; i++) begin
            assert (mem_i.mem_q[i] === ref_mem[i]) else begin
                errors++;
                $display("[FAIL] %0t mem_q word %0d after flush: got %h expected %h",
                         $time, i, mem_i.mem_q[i], ref_mem[i]);
            end
        end
    endtask

    initial begin
        logic [31:0]       rnd;
        logic [ADDR_W-1:0] addr;
        seed     = 32'h4d78ebcf;
        errors   = 0;
        n_access = 0;
        n_wb     = 0;
        n_flush  = 0;
        rst_n     <= 1'b0;
        lsu_req   <= 1'b0;
        lsu_wr    <= 1'b0;
        lsu_addr  <= '0;
        lsu_sel   <= '0;
        lsu_wdata <= '0;
        flush     <= 1'b0;
        dmem_sel  <= 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // Reference starts as a copy of main memory
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = mem_i.mem_q[i];
        end
        @(posedge clk);
        for (int round = 0; round < 4; round++) begin
            // Four tags per set in range, so sets keep conflicting
            for (int k = 0; k < 60; k++) begin
                rnd  = $random(seed);
                addr = {22'd0, rnd[11:4], 2'b00};
                run_access(rnd[0], addr, rnd[15:12], $random(seed), 1'b0, 1'b0);
                run_access(1'b0, addr, 4'hf, '0, 1'b1, 1'b0);
            end
            rnd = $random(seed);
            check_deselect({22'd0, rnd[9:2], 2'b00});
            run_flush();
            for (int s = 0; s < SETS; s++) begin
                rnd = $random(seed);
                run_access(1'b0, {22'd0, rnd[1:0], 4'(s), rnd[3:2], 2'b00}, 4'hf, '0,
                           1'b0, 1'b1);
            end
        end
        $display("Summary: %0d accesses, %0d write-backs, %0d flushes, %0d errors",
                 n_access, n_wb, n_flush, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- wb_dcache.f
hw/dcache_pkg.sv
hw/wb_dcache_controller.sv
hw/wb_dcache_datapath.sv
hw/wb_dcache_top.sv
sim/tb_mem_model.sv
sim/tb_wb_dcache.sv
